/* Makefile */
# Verilator build and run of the memory subsystem testbench
# Override any variable on the command line, e.g. make test TOP=memSubsystemTb

VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= memSubsystem.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert
PASS_TEXT := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR, TOP, FILELIST, OBJ_DIR, FLAGS"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
	  echo "Simulation result: PASS"; \
	else \
	  echo "Simulation result: FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

/* common/memCfgPkg.sv */
// --------------------
// Memory configuration
// Geometry of the data memory and of the
// 16-kbit block RAM it is built from
// --------------------
package memCfgPkg;

  // Data memory as seen by the system
  localparam int unsigned NumWords  = 4096;
  localparam int unsigned DataWidth = 48;
  localparam int unsigned ByteWidth = 8;               // Only 8-bit bytes supported
  localparam int unsigned AddrWidth = $clog2(NumWords);
  localparam int unsigned BeWidth   = DataWidth / ByteWidth;

  // Block RAM primitive
  localparam int unsigned BramPortWidth = 32;          // Widest port mode
  localparam int unsigned BramAddrBits  = 14;          // AD field, byte enables in the low bits
  localparam int unsigned BramBits      = 1 << BramAddrBits; // 16 kbit per block

  // Tiling of the data word into block RAM columns
  localparam int unsigned NumColumns = (DataWidth + BramPortWidth - 1) / BramPortWidth;

  // The block select input of the primitive is 3 bits wide,
  // so a column can stack at most eight blocks
  localparam int unsigned MaxRows    = 8;
  localparam int unsigned RowSelBits = $clog2(MaxRows);

endpackage

/* common/memReqPkg.sv */
// --------------------
// Memory request and response types
// passed between top level and tiled SRAM
// --------------------
package memReqPkg;

  typedef logic [memCfgPkg::AddrWidth-1:0] memAddr_t; // Word address
  typedef logic [memCfgPkg::DataWidth-1:0] memData_t; // Data word
  typedef logic [memCfgPkg::BeWidth-1:0]   memBe_t;   // One enable per byte

  // One request per cycle, no handshake
  typedef struct packed {
    logic     req;   // Strobe, accepted every cycle it is high
    logic     we;    // High for write, low for read
    memAddr_t addr;
    memData_t wdata;
    memBe_t   be;    // Write byte enables
  } memReq_t;

  // Read data arrives one cycle after the request
  typedef struct packed {
    logic     rvalid; // Single cycle pulse per read
    memData_t rdata;
  } memRsp_t;

endpackage

/* memSubsystem.f */
common/memCfgPkg.sv
common/memReqPkg.sv
source/spBlockRam.sv
sram/bramColumn.sv
sram/sramTiled.sv
source/memSubsystem.sv
verification/memSubsystemTb.sv

/* source/memSubsystem.sv */
// --------------------
// Memory subsystem
// Data memory of the soft core
// --------------------
`timescale 1ns/100ps

module memSubsystem (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  memReqPkg::memReq_t req_i,  // One request per cycle
  output memReqPkg::memRsp_t rsp_o   // Read data, one cycle later
);

  // 4096 x 48 bit data memory
  sramTiled #(
    .addr_t (memReqPkg::memAddr_t),
    .data_t (memReqPkg::memData_t),
    .be_t   (memReqPkg::memBe_t)
  ) dataMem_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_i),
    .rsp_o  (rsp_o)
  );

endmodule

/* source/spBlockRam.sv */
// --------------------
// Single-port block RAM model
// 16 kbit, block select, byte enables in the address field
// --------------------
`timescale 1ns/100ps

module spBlockRam #(
  parameter int unsigned BitWidth   = 32, // Port mode, 16 or 32
  parameter int unsigned BlockIndex = 0   // Block select value this RAM answers to
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                ce_i,
  input  logic                                we_i,
  input  logic [memCfgPkg::RowSelBits-1:0]    blkSel_i,
  input  logic [memCfgPkg::BramAddrBits-1:0]  addrBe_i,
  input  logic [memCfgPkg::BramPortWidth-1:0] wdata_i,
  output logic [memCfgPkg::BramPortWidth-1:0] rdata_o
);
  import memCfgPkg::*;

  localparam int unsigned NumBytes = BitWidth / ByteWidth;
  localparam int unsigned Depth    = BramBits / BitWidth;  // 512 or 1024 words
  localparam int unsigned WordBits = $clog2(Depth);

  logic [BitWidth-1:0] mem [Depth] = '{default: '0}; // Content starts cleared
  logic [WordBits-1:0] wordAddr;
  logic [NumBytes-1:0] byteEn;
  logic                selected;
  logic [BitWidth-1:0] rdataQ;

  // Word address sits in the top bits, byte enables in the bottom bits
  assign wordAddr = addrBe_i[BramAddrBits-1 -: WordBits];
  assign byteEn   = addrBe_i[NumBytes-1:0];

  // Only the block whose index matches the select takes part
  assign selected = ce_i && (blkSel_i == RowSelBits'(BlockIndex));

  always_ff @(posedge clk_i) begin : writePort
    if (selected && we_i) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (byteEn[b]) begin
          mem[wordAddr][b*ByteWidth +: ByteWidth] <= wdata_i[b*ByteWidth +: ByteWidth];
        end
      end
    end
  end

  // Output register, left untouched on write cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin : readPort
    if (!rst_ni) begin
      rdataQ <= '0;
    end else if (selected && !we_i) begin
      rdataQ <= mem[wordAddr];
    end
  end

  // Narrow modes leave the upper port bits at zero
  always_comb begin
    rdata_o                = '0;
    rdata_o[BitWidth-1:0]  = rdataQ;
  end

endmodule

/* sram/bramColumn.sv */
// --------------------
// Block RAM column
// Stacks block RAMs in rows, decodes the row from
// the upper address bits and muxes the read data
// --------------------
`timescale 1ns/100ps

module bramColumn #(
  parameter type         colData_t   = logic [31:0],
  parameter int unsigned ColumnWidth = $bits(colData_t) // 32 or 16
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_i,
  input  logic                                      we_i,
  input  memReqPkg::memAddr_t                       addr_i,
  input  colData_t                                  wdata_i,
  input  logic [ColumnWidth/memCfgPkg::ByteWidth-1:0] be_i,
  output colData_t                                  rdata_o
);
  import memCfgPkg::*;

  // Geometry of this column
  localparam int unsigned NumBytes     = ColumnWidth / ByteWidth;
  localparam int unsigned WordsPerBram = BramBits / ColumnWidth;
  localparam int unsigned InBlockBits  = $clog2(WordsPerBram);
  localparam int unsigned NumRows      = (NumWords + WordsPerBram - 1) / WordsPerBram;
  localparam int unsigned RowBits      = $clog2(NumRows);

  logic [RowBits-1:0]       row;
  logic [RowBits-1:0]       rowQ;    // Row of the last accepted request
  logic [RowSelBits-1:0]    blkSel;
  logic [BramAddrBits-1:0]  addrBe;
  logic [BramPortWidth-1:0] wdataPad;
  logic [BramPortWidth-1:0] bramRdata [NumRows];

  // Upper address bits pick the row
  assign row    = addr_i[AddrWidth-1 -: RowBits];
  assign blkSel = RowSelBits'(row);

  // Pack the in-block word address above the byte enables
  always_comb begin
    addrBe                                     = '0;
    addrBe[NumBytes-1:0]                       = be_i;
    addrBe[BramAddrBits-1 -: InBlockBits]      = addr_i[InBlockBits-1:0];
  end

  always_comb begin
    wdataPad                    = '0;
    wdataPad[ColumnWidth-1:0]   = wdata_i; // Unused port bits stay zero
  end

  // Remember which row answers the read in the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rowQ <= '0;
    end else if (req_i) begin
      rowQ <= row;
    end
  end

  assign rdata_o = colData_t'(bramRdata[rowQ][ColumnWidth-1:0]);

  for (genvar r = 0; r < NumRows; r++) begin : genRow
    spBlockRam #(
      .BitWidth   (ColumnWidth),
      .BlockIndex (r)
    ) bram_inst (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .ce_i     (req_i),
      .we_i     (we_i),
      .blkSel_i (blkSel),      // Each block compares against its own index
      .addrBe_i (addrBe),
      .wdata_i  (wdataPad),
      .rdata_o  (bramRdata[r])
    );
  end

endmodule

/* sram/sramTiled.sv */
// --------------------
// Tiled SRAM
// Builds the data word from block RAM columns
// and returns read data with a valid pulse
// --------------------
`timescale 1ns/100ps

module sramTiled #(
  parameter type addr_t = memReqPkg::memAddr_t,
  parameter type data_t = memReqPkg::memData_t,
  parameter type be_t   = memReqPkg::memBe_t
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  memReqPkg::memReq_t req_i,
  output memReqPkg::memRsp_t rsp_o
);
  import memCfgPkg::*;

  // Column 0 takes a full block RAM port, column 1 the rest of the word
  localparam int unsigned Col0Width = BramPortWidth;
  localparam int unsigned Col1Width = $bits(data_t) - Col0Width;
  localparam int unsigned Col0Bytes = Col0Width / ByteWidth;

  typedef logic [Col0Width-1:0] col0Data_t;
  typedef logic [Col1Width-1:0] col1Data_t;

  addr_t     addr;
  data_t     wdata;
  data_t     rdata;
  be_t       be;
  col0Data_t col0Rdata;
  col1Data_t col1Rdata;
  logic      rvalidQ;

  assign addr  = req_i.addr;
  assign wdata = req_i.wdata;
  assign be    = req_i.be;

  // Low word bits in column 0
  bramColumn #(
    .colData_t   (col0Data_t),
    .ColumnWidth (Col0Width)
  ) col0_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i.req),
    .we_i    (req_i.we),
    .addr_i  (addr),
    .wdata_i (wdata[Col0Width-1:0]),
    .be_i    (be[Col0Bytes-1:0]),
    .rdata_o (col0Rdata)
  );

  // Upper bits in the narrower column 1
  bramColumn #(
    .colData_t   (col1Data_t),
    .ColumnWidth (Col1Width)
  ) col1_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i.req),
    .we_i    (req_i.we),
    .addr_i  (addr),
    .wdata_i (wdata[$bits(data_t)-1:Col0Width]),
    .be_i    (be[$bits(be_t)-1:Col0Bytes]),
    .rdata_o (col1Rdata)
  );

  assign rdata = {col1Rdata, col0Rdata};

  // Read data is ready one cycle after a read request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalidQ <= 1'b0;
    end else begin
      rvalidQ <= req_i.req && !req_i.we;
    end
  end

  assign rsp_o.rvalid = rvalidQ;
  assign rsp_o.rdata  = rdata;

endmodule

/* verification/memSubsystemTb.sv */
// --------------------
// Memory subsystem testbench
// Shadow memory model and concurrent assertion checks
// --------------------
`timescale 1ns/100ps

module memSubsystemTb;
  import memReqPkg::*;

  localparam int unsigned NumWords      = 4096;
  localparam int unsigned ResetCycles   = 8;
  localparam int unsigned RandomCycles  = 400;
  localparam int unsigned TimeoutCycles = 6000; // Well above the length of all tests

  logic     clk_i;
  logic     rst_ni;
  memReq_t  req;
  memRsp_t  rsp;

  memData_t shadow [NumWords] = '{default: '0}; // Memory starts cleared
  memData_t expWord;      // Expected word of the read in flight
  logic     readIssuedQ;  // Read accepted at the last edge
  int       errCount;
  int       testsPassed;
  int       testsFailed;
  int       cycleCount;
  integer   seed;

  memSubsystem memSubsystem_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req),
    .rsp_o  (rsp)
  );

  always #20 clk_i = ~clk_i;

  // New word with only the enabled bytes taken from the write data
  function automatic memData_t mergeBytes(memData_t oldWord, memData_t newWord, memBe_t be);
    memData_t result;
    result = oldWord;
    for (int b = 0; b < $bits(memBe_t); b++) begin
      if (be[b]) begin
        result[b*8 +: 8] = newWord[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // Reference model following every accepted request
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      readIssuedQ <= 1'b0;
      expWord     <= '0;
    end else begin
      readIssuedQ <= req.req && !req.we;
      if (req.req && req.we) begin
        shadow[req.addr] <= mergeBytes(shadow[req.addr], req.wdata, req.be);
      end else if (req.req) begin
        expWord <= shadow[req.addr]; // Sees writes of earlier cycles
      end
    end
  end

  rvalidCheck: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp.rvalid == readIssuedQ)
    else begin
      $display("ERROR at %0t: rsp_o.rvalid expected %0b, actual %0b",
               $time, $sampled(readIssuedQ), $sampled(rsp.rvalid));
      errCount++;
    end

  rdataCheck: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp.rvalid |-> rsp.rdata == expWord)
    else begin
      $display("ERROR at %0t: rsp_o.rdata expected %h, actual %h",
               $time, $sampled(expWord), $sampled(rsp.rdata));
      errCount++;
    end

  resetCheck: assert property (@(posedge clk_i) !rst_ni |-> !rsp.rvalid)
    else begin
      $display("ERROR at %0t: rsp_o.rvalid expected 0, actual %0b during reset",
               $time, $sampled(rsp.rvalid));
      errCount++;
    end

  task automatic writeWord(input memAddr_t addr, input memData_t data, input memBe_t be);
    @(posedge clk_i);
    #1;
    req.req   = 1'b1;
    req.we    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    req.be    = be;
  endtask

  task automatic readWord(input memAddr_t addr);
    @(posedge clk_i);
    #1;
    req.req   = 1'b1;
    req.we    = 1'b0;
    req.addr  = addr;
    req.wdata = '0;
    req.be    = '0;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      req = '0;
    end
  endtask

  task automatic reportTest(input int num, input string name, input int startErr);
    int errors;
    errors = errCount - startErr;
    if (errors == 0) begin
      testsPassed++;
      $display("Test %0d %s: passed", num, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: failed with %0d errors", num, name, errors);
    end
  endtask

  initial begin : watchdog
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk_i);
      cycleCount++;
    end
    $display("Simulation timed out after %0d cycles", cycleCount);
    $display("Regression failed");
    $finish;
  end

  initial begin : stimulus
    int       startErr;
    memAddr_t boundary [8];
    memAddr_t hot [6];
    logic [31:0] r;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req         = '0;
    req.req     = 1'b1;   // Reads held during reset must not raise rvalid
    errCount    = 0;
    testsPassed = 0;
    testsFailed = 0;
    cycleCount  = 0;
    seed        = 32'h9a2d_da68;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    req    = '0;

    // Unwritten words read back as zero
    startErr = errCount;
    idleCycles(2);
    readWord(12'd0);
    readWord(12'd777);
    readWord(12'd4095);
    idleCycles(2);
    reportTest(1, "reset and unwritten reads", startErr);

    // Column 0 rows are 512 words, column 1 rows 1024 words
    startErr = errCount;
    boundary = '{12'd0, 12'd511, 12'd512, 12'd1023, 12'd1024, 12'd2047, 12'd2048, 12'd4095};
    foreach (boundary[i]) begin
      writeWord(boundary[i], {4'h9, boundary[i], 4'hC, ~boundary[i], 4'h3,
                              boundary[i] ^ 12'hA5A}, 6'h3F);
    end
    foreach (boundary[i]) begin
      readWord(boundary[i]);
      idleCycles(1);
    end
    idleCycles(2);
    reportTest(2, "row boundaries", startErr);

    // Partial writes over both columns
    startErr = errCount;
    writeWord(12'd1500, 48'h1122_3344_5566, 6'h3F);
    readWord(12'd1500);
    writeWord(12'd1500, 48'hAAAA_AAAA_AAAA, 6'b000001);
    readWord(12'd1500);
    writeWord(12'd1500, 48'hBBBB_BBBB_BBBB, 6'b100100);
    readWord(12'd1500);
    writeWord(12'd1500, 48'hCCCC_CCCC_CCCC, 6'b010010);
    readWord(12'd1500);
    writeWord(12'd1500, 48'hDDDD_DDDD_DDDD, 6'b000000); // No byte changes
    readWord(12'd1500);
    idleCycles(2);
    reportTest(3, "byte enables", startErr);

    // One read per cycle with no gaps
    startErr = errCount;
    hot = '{12'd100, 12'd600, 12'd1100, 12'd2100, 12'd3100, 12'd4000};
    foreach (hot[i]) begin
      writeWord(hot[i], memData_t'({$random(seed), $random(seed)}), 6'h3F);
    end
    for (int i = 0; i < 12; i++) begin
      readWord(hot[i % 6]);
    end
    readWord(12'd3333);
    idleCycles(2);
    reportTest(4, "back-to-back reads", startErr);

    // Mixed traffic with addresses folded so reads often hit written words
    startErr = errCount;
    for (int i = 0; i < RandomCycles; i++) begin
      r = $random(seed);
      if (r[0]) begin
        writeWord(memAddr_t'($random(seed)) & 12'hF07,
                  memData_t'({$random(seed), $random(seed)}), memBe_t'($random(seed)));
      end else begin
        readWord(memAddr_t'($random(seed)) & 12'hF07);
      end
    end
    idleCycles(2);
    reportTest(5, "random traffic", startErr);

    $display("Tests passed: %0d, tests failed: %0d, assertion errors: %0d",
             testsPassed, testsFailed, errCount);
    if (errCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
